// File: hw/activity_led.sv
/*
 Pulse stretcher for the disk activity lights.
 Every pulse reloads a down-counter, the output stays lit while
 the counter runs.
*/
`timescale 1ns/100ps
`default_nettype none

module activity_led #(
	parameter int HOLD_LEN = x68k_timing_pkg::DEF_LED_HOLD_LEN
) (
	input  wire  clk_sys,
	input  wire  reset_delayed,
	input  wire  pulse_i,
	output logic active_o
);

	localparam int CNT_W = $clog2(HOLD_LEN + 1);

	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			hold_cnt <= '0;
			active_o <= 1'b0;
		end else begin
			if (pulse_i)
				hold_cnt <= CNT_W'(HOLD_LEN);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - CNT_W'(1);
			active_o <= pulse_i || (hold_cnt != '0);
		end
	end

endmodule

`default_nettype wire

// File: hw/clock_enable_gen.sv
/*
 Clock enables for the core.
 Free-running dividers on clk_sys give the system, CPU phase, sound
 and FM synth enables. Turbo switches the CPU phases to every cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module clock_enable_gen (
	input  wire        clk_sys,
	input  wire        reset_delayed,
	input  wire        turbo_i,
	input  wire        snd_clockmode_i,
	output logic       sys_ce_o,
	output logic       mpu_cep_o,
	output logic       mpu_cen_o,
	output logic       snd_ce_o,
	output logic [1:0] opm_ce_o
);

	localparam int SYS_W = $clog2(x68k_timing_pkg::SYS_CE_DIV);
	localparam int FAST_W = $clog2(x68k_timing_pkg::SND_DIV_FAST);
	localparam int SLOW_W = $clog2(x68k_timing_pkg::SND_DIV_SLOW);
	localparam int OPMA_W = $clog2(x68k_timing_pkg::OPM_DIV_A);
	localparam int OPMB_W = $clog2(x68k_timing_pkg::OPM_DIV_B);

	localparam logic [SYS_W-1:0] SYS_LAST = SYS_W'(x68k_timing_pkg::SYS_CE_DIV - 1);
	// Negative phase sits halfway through the system period
	localparam logic [SYS_W-1:0] SYS_HALF = SYS_W'(x68k_timing_pkg::SYS_CE_DIV / 2 - 1);
	localparam logic [FAST_W-1:0] FAST_LAST = FAST_W'(x68k_timing_pkg::SND_DIV_FAST - 1);
	localparam logic [SLOW_W-1:0] SLOW_LAST = SLOW_W'(x68k_timing_pkg::SND_DIV_SLOW - 1);
	localparam logic [OPMA_W-1:0] OPMA_LAST = OPMA_W'(x68k_timing_pkg::OPM_DIV_A - 1);
	localparam logic [OPMB_W-1:0] OPMB_LAST = OPMB_W'(x68k_timing_pkg::OPM_DIV_B - 1);

	logic [SYS_W-1:0]  div_sys;
	logic [FAST_W-1:0] div_fast;
	logic [SLOW_W-1:0] div_slow;
	logic [OPMA_W-1:0] div_opm_a;
	logic [OPMB_W-1:0] div_opm_b;
	logic              turbo;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			div_sys <= '0;
			div_fast <= '0;
			div_slow <= '0;
			div_opm_a <= '0;
			div_opm_b <= '0;
			turbo <= 1'b0;
			sys_ce_o <= 1'b0;
			mpu_cep_o <= 1'b0;
			mpu_cen_o <= 1'b0;
			snd_ce_o <= 1'b0;
			opm_ce_o <= '0;
		end else begin
			div_sys <= (div_sys == SYS_LAST) ? '0 : div_sys + SYS_W'(1);
			div_fast <= (div_fast == FAST_LAST) ? '0 : div_fast + FAST_W'(1);
			div_slow <= (div_slow == SLOW_LAST) ? '0 : div_slow + SLOW_W'(1);
			div_opm_a <= (div_opm_a == OPMA_LAST) ? '0 : div_opm_a + OPMA_W'(1);
			div_opm_b <= (div_opm_b == OPMB_LAST) ? '0 : div_opm_b + OPMB_W'(1);

			// Mode change only between system periods
			if (div_sys == SYS_LAST)
				turbo <= turbo_i;

			sys_ce_o <= (div_sys == SYS_LAST);
			mpu_cep_o <= turbo ? div_sys[0] : (div_sys == SYS_LAST);
			mpu_cen_o <= turbo ? ~div_sys[0] : (div_sys == SYS_HALF);
			snd_ce_o <= snd_clockmode_i ? (div_slow == SLOW_LAST) : (div_fast == FAST_LAST);
			opm_ce_o <= {div_opm_b == OPMB_LAST, div_opm_a == OPMA_LAST};
		end
	end

endmodule

`default_nettype wire

// File: hw/host_status_regs.sv
/*
 Host status and joystick registers.
 Samples the status word and both pads once per clock and decodes
 them into the control fields the core and the sequencer expect.
*/
`timescale 1ns/100ps
`default_nettype none

module host_status_regs (
	input  wire                          clk_sys,
	input  wire                          reset_delayed,
	input  x68k_host_pkg::status_word_t  status_i,
	input  x68k_host_pkg::host_joy_t     joy0_i,
	input  x68k_host_pkg::host_joy_t     joy1_i,
	input  wire  [1:0]                   buttons_i,
	output logic                         turbo_o,
	output logic                         reset_req_o,
	output x68k_host_pkg::fdd_mask_t     fdd_eject_req_o,
	output logic                         vid_hz_o,
	output logic [1:0]                   psw_n_o,
	output x68k_host_pkg::fdd_mask_t     fdsync_o,
	output logic                         sram_ld_o,
	output logic                         sram_st_o,
	output x68k_host_pkg::core_joy_t     core_joy_a_o,
	output x68k_host_pkg::core_joy_t     core_joy_b_o
);

	// Fire 2, fire 1, then the directions merged with the diagonal pad
	function automatic x68k_host_pkg::core_joy_t map_joy(input x68k_host_pkg::host_joy_t j);
		return ~{j[5:4], j[0] | j[6], j[1] | j[6], j[2] | j[7], j[3] | j[7]};
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			turbo_o <= 1'b0;
			reset_req_o <= 1'b0;
			fdd_eject_req_o <= '0;
		end else begin
			turbo_o <= status_i[x68k_host_pkg::ST_TURBO];
			reset_req_o <= status_i[x68k_host_pkg::ST_RESET] | buttons_i[1];
			fdd_eject_req_o <= status_i[x68k_host_pkg::ST_EJECT_LO +: x68k_timing_pkg::NUM_FDD];
		end
	end

	// Plain field decode for the core
	always_ff @(posedge clk_sys) begin
		vid_hz_o <= ~status_i[x68k_host_pkg::ST_VID_HZ];
		psw_n_o <= ~{status_i[x68k_host_pkg::ST_NMI], status_i[x68k_host_pkg::ST_POWER]};
		fdsync_o <= status_i[x68k_host_pkg::ST_FDSYNC_LO +: x68k_timing_pkg::NUM_FDD];
		sram_ld_o <= status_i[x68k_host_pkg::ST_SRAM_LD];
		sram_st_o <= status_i[x68k_host_pkg::ST_SRAM_ST];
		core_joy_a_o <= map_joy(joy0_i);
		core_joy_b_o <= map_joy(joy1_i);
	end

endmodule

`default_nettype wire

// File: hw/loader_bridge.sv
/*
 Download bridge into the core loader.
 Each host write is captured and presented with ldr_wr_o held high
 until the core acknowledges it. Also flags the end of the download.
*/
`timescale 1ns/100ps
`default_nettype none

module loader_bridge (
	input  wire         clk_sys,
	input  wire         reset_delayed,
	input  wire         ioctl_download_i,
	input  wire         ioctl_wr_i,
	input  wire  [19:0] ioctl_addr_i,
	input  wire  [7:0]  ioctl_dout_i,
	input  wire         ldr_ack_i,
	output logic [19:0] ldr_addr_o,
	output logic [7:0]  ldr_wdat_o,
	output logic        ldr_wr_o,
	output logic        ldr_aen_o,
	output logic        ldr_done_o,
	output logic        boot_seen_o,
	output logic        download_led_o
);

	logic download_q;
	logic ack_q;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			download_q <= 1'b0;
			ack_q <= 1'b0;
			ldr_wr_o <= 1'b0;
			ldr_aen_o <= 1'b0;
			ldr_done_o <= 1'b0;
			boot_seen_o <= 1'b0;
			download_led_o <= 1'b1;
		end else begin
			download_q <= ioctl_download_i;
			ack_q <= ldr_ack_i;
			ldr_aen_o <= ioctl_download_i && !ldr_done_o;
			download_led_o <= !ioctl_download_i;

			// Drop the strobe on the ack rising edge
			if (!ack_q && ldr_ack_i && ldr_wr_o)
				ldr_wr_o <= 1'b0;
			if (ioctl_wr_i && !ldr_done_o)
				ldr_wr_o <= 1'b1;

			if (download_q && !ioctl_download_i)
				ldr_done_o <= 1'b1;
			if (!download_q && ioctl_download_i)
				boot_seen_o <= 1'b1;
		end
	end

	// A late write simply overwrites the held word
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i && !ldr_done_o) begin
			ldr_addr_o <= ioctl_addr_i;
			ldr_wdat_o <= ioctl_dout_i;
		end
	end

endmodule

`default_nettype wire

// File: hw/media_reset_seq.sv
/*
 Media change and core reset sequencer.
 A mount pulse plays an eject phase and then a present phase to the
 core so the guest sees the disk change. Also builds the core reset.
*/
`timescale 1ns/100ps
`default_nettype none

module media_reset_seq #(
	parameter int MOUNT_EJECT_LEN = x68k_timing_pkg::DEF_MOUNT_EJECT_LEN,
	parameter int MOUNT_PRESENT_LEN = x68k_timing_pkg::DEF_MOUNT_PRESENT_LEN,
	parameter int EJECT_LEN = x68k_timing_pkg::DEF_EJECT_LEN,
	parameter int HDD_RESET_LEN = x68k_timing_pkg::DEF_HDD_RESET_LEN
) (
	input  wire                          clk_sys,
	input  wire                          reset_delayed,
	input  x68k_host_pkg::drive_mask_t   img_mounted_i,
	input  x68k_host_pkg::fdd_mask_t     fdd_eject_req_i,
	input  wire                          reset_req_i,
	input  wire                          status_reset_i,
	input  wire                          boot_seen_i,
	output x68k_host_pkg::fdd_mask_t     fdd_eject_o,
	output x68k_host_pkg::fdd_mask_t     fdd_mounted_o,
	output logic                         hdd_mounted_o,
	output logic                         sram_mounted_o,
	output logic                         core_rst_n_o
);

	localparam int MOUNT_TOTAL = MOUNT_EJECT_LEN + MOUNT_PRESENT_LEN;
	localparam int MCNT_W = $clog2(MOUNT_TOTAL + 1);
	localparam int ECNT_W = $clog2(EJECT_LEN + 1);
	localparam int HCNT_W = $clog2(HDD_RESET_LEN + 1);
	localparam int SRAM_SLOT = x68k_timing_pkg::NUM_DRIVES - 1;

	logic [MCNT_W-1:0] mount_cnt [x68k_timing_pkg::NUM_DRIVES];
	logic [ECNT_W-1:0] eject_cnt [x68k_timing_pkg::NUM_FDD];
	logic [HCNT_W-1:0] hdd_rst_cnt;
	logic              hdd_mount_q;
	logic              status_reset_q;
	logic              init_done;
	x68k_host_pkg::fdd_mask_t eject_phase;
	x68k_host_pkg::fdd_mask_t present_phase;

	//////////////////////////////////////////////////////////////////////
	// Hold counters

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			for (int i = 0; i < x68k_timing_pkg::NUM_DRIVES; i++)
				mount_cnt[i] <= '0;
			for (int i = 0; i < x68k_timing_pkg::NUM_FDD; i++)
				eject_cnt[i] <= '0;
			hdd_rst_cnt <= '0;
			hdd_mount_q <= 1'b0;
			status_reset_q <= 1'b0;
			init_done <= 1'b0;
		end else begin
			for (int i = 0; i < x68k_timing_pkg::NUM_DRIVES; i++) begin
				if (img_mounted_i[i])
					mount_cnt[i] <= MCNT_W'(MOUNT_TOTAL);
				else if (mount_cnt[i] != '0)
					mount_cnt[i] <= mount_cnt[i] - MCNT_W'(1);
			end
			// Request held high keeps the drive ejected
			for (int i = 0; i < x68k_timing_pkg::NUM_FDD; i++) begin
				if (fdd_eject_req_i[i])
					eject_cnt[i] <= ECNT_W'(EJECT_LEN);
				else if (eject_cnt[i] != '0)
					eject_cnt[i] <= eject_cnt[i] - ECNT_W'(1);
			end

			// New hard disk image restarts the machine
			hdd_mount_q <= img_mounted_i[x68k_timing_pkg::HDD_SLOT];
			if (img_mounted_i[x68k_timing_pkg::HDD_SLOT] && !hdd_mount_q)
				hdd_rst_cnt <= HCNT_W'(HDD_RESET_LEN);
			else if (hdd_rst_cnt != '0)
				hdd_rst_cnt <= hdd_rst_cnt - HCNT_W'(1);

			// Host holds reset at power up, release marks init done
			status_reset_q <= status_reset_i;
			if (status_reset_q && !status_reset_i)
				init_done <= 1'b1;
		end
	end

	// Eject phase is the upper part of the mount count
	always_comb begin
		for (int i = 0; i < x68k_timing_pkg::NUM_FDD; i++) begin
			eject_phase[i] = (mount_cnt[i] > MCNT_W'(MOUNT_PRESENT_LEN)) || (eject_cnt[i] != '0);
			present_phase[i] = !eject_phase[i] && (mount_cnt[i] != '0);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered outputs

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			fdd_eject_o <= '0;
			fdd_mounted_o <= '0;
			hdd_mounted_o <= 1'b0;
			sram_mounted_o <= 1'b0;
			core_rst_n_o <= 1'b0;
		end else begin
			fdd_eject_o <= eject_phase;
			fdd_mounted_o <= present_phase;
			hdd_mounted_o <= (mount_cnt[x68k_timing_pkg::HDD_SLOT] != '0);
			sram_mounted_o <= (mount_cnt[SRAM_SLOT] != '0);
			core_rst_n_o <= boot_seen_i && init_done && !reset_req_i && !status_reset_i &&
				(hdd_rst_cnt == '0);
		end
	end

endmodule

`default_nettype wire

// File: hw/x68k_glue_top.sv
/*
 Glue between the host controller and the X68000 core.
 Connects the status decode, clock enables, media sequencer, loader
 bridge and the two disk lights. Hold lengths are set here.
*/
`timescale 1ns/100ps
`default_nettype none

module x68k_glue_top #(
	parameter int MOUNT_EJECT_LEN = x68k_timing_pkg::DEF_MOUNT_EJECT_LEN,
	parameter int MOUNT_PRESENT_LEN = x68k_timing_pkg::DEF_MOUNT_PRESENT_LEN,
	parameter int EJECT_LEN = x68k_timing_pkg::DEF_EJECT_LEN,
	parameter int HDD_RESET_LEN = x68k_timing_pkg::DEF_HDD_RESET_LEN,
	parameter int LED_HOLD_LEN = x68k_timing_pkg::DEF_LED_HOLD_LEN
) (
	input  wire                          clk_sys,
	input  wire                          reset_delayed,
	// Host side
	input  x68k_host_pkg::status_word_t  status_i,
	input  x68k_host_pkg::host_joy_t     joy0_i,
	input  x68k_host_pkg::host_joy_t     joy1_i,
	input  wire  [1:0]                   buttons_i,
	input  x68k_host_pkg::drive_mask_t   img_mounted_i,
	input  x68k_host_pkg::drive_mask_t   sd_ack_i,
	input  wire                          ioctl_download_i,
	input  wire                          ioctl_wr_i,
	input  wire  [19:0]                  ioctl_addr_i,
	input  wire  [7:0]                   ioctl_dout_i,
	// Core side
	input  wire                          snd_clockmode_i,
	input  wire                          ldr_ack_i,
	output logic                         sys_ce_o,
	output logic                         mpu_cep_o,
	output logic                         mpu_cen_o,
	output logic                         snd_ce_o,
	output logic [1:0]                   opm_ce_o,
	output logic                         core_rst_n_o,
	output x68k_host_pkg::fdd_mask_t     fdd_eject_o,
	output x68k_host_pkg::fdd_mask_t     fdd_mounted_o,
	output logic                         hdd_mounted_o,
	output logic                         sram_mounted_o,
	output logic                         vid_hz_o,
	output logic [1:0]                   psw_n_o,
	output x68k_host_pkg::fdd_mask_t     fdsync_o,
	output logic                         sram_ld_o,
	output logic                         sram_st_o,
	output x68k_host_pkg::core_joy_t     core_joy_a_o,
	output x68k_host_pkg::core_joy_t     core_joy_b_o,
	output logic [19:0]                  ldr_addr_o,
	output logic [7:0]                   ldr_wdat_o,
	output logic                         ldr_wr_o,
	output logic                         ldr_aen_o,
	output logic                         ldr_done_o,
	output logic                         download_led_o,
	output logic                         fdd_active_o,
	output logic                         hdd_active_o
);

	logic                     turbo;
	logic                     reset_req;
	logic                     boot_seen;
	x68k_host_pkg::fdd_mask_t fdd_eject_req;

	//////////////////////////////////////////////////////////////////////
	// Configuration and timing

	host_status_regs u_status (
		.clk_sys         (clk_sys),
		.reset_delayed   (reset_delayed),
		.status_i        (status_i),
		.joy0_i          (joy0_i),
		.joy1_i          (joy1_i),
		.buttons_i       (buttons_i),
		.turbo_o         (turbo),
		.reset_req_o     (reset_req),
		.fdd_eject_req_o (fdd_eject_req),
		.vid_hz_o        (vid_hz_o),
		.psw_n_o         (psw_n_o),
		.fdsync_o        (fdsync_o),
		.sram_ld_o       (sram_ld_o),
		.sram_st_o       (sram_st_o),
		.core_joy_a_o    (core_joy_a_o),
		.core_joy_b_o    (core_joy_b_o)
	);

	clock_enable_gen u_ce (
		.clk_sys         (clk_sys),
		.reset_delayed   (reset_delayed),
		.turbo_i         (turbo),
		.snd_clockmode_i (snd_clockmode_i),
		.sys_ce_o        (sys_ce_o),
		.mpu_cep_o       (mpu_cep_o),
		.mpu_cen_o       (mpu_cen_o),
		.snd_ce_o        (snd_ce_o),
		.opm_ce_o        (opm_ce_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Media, reset and loader

	media_reset_seq #(
		.MOUNT_EJECT_LEN   (MOUNT_EJECT_LEN),
		.MOUNT_PRESENT_LEN (MOUNT_PRESENT_LEN),
		.EJECT_LEN         (EJECT_LEN),
		.HDD_RESET_LEN     (HDD_RESET_LEN)
	) u_media (
		.clk_sys         (clk_sys),
		.reset_delayed   (reset_delayed),
		.img_mounted_i   (img_mounted_i),
		.fdd_eject_req_i (fdd_eject_req),
		.reset_req_i     (reset_req),
		.status_reset_i  (status_i[x68k_host_pkg::ST_RESET]),
		.boot_seen_i     (boot_seen),
		.fdd_eject_o     (fdd_eject_o),
		.fdd_mounted_o   (fdd_mounted_o),
		.hdd_mounted_o   (hdd_mounted_o),
		.sram_mounted_o  (sram_mounted_o),
		.core_rst_n_o    (core_rst_n_o)
	);

	loader_bridge u_loader (
		.clk_sys          (clk_sys),
		.reset_delayed    (reset_delayed),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ldr_ack_i        (ldr_ack_i),
		.ldr_addr_o       (ldr_addr_o),
		.ldr_wdat_o       (ldr_wdat_o),
		.ldr_wr_o         (ldr_wr_o),
		.ldr_aen_o        (ldr_aen_o),
		.ldr_done_o       (ldr_done_o),
		.boot_seen_o      (boot_seen),
		.download_led_o   (download_led_o)
	);

	// Both floppies share one light
	activity_led #(.HOLD_LEN(LED_HOLD_LEN)) u_fdd_led (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.pulse_i       (|sd_ack_i[x68k_timing_pkg::NUM_FDD-1:0]),
		.active_o      (fdd_active_o)
	);

	activity_led #(.HOLD_LEN(LED_HOLD_LEN)) u_hdd_led (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.pulse_i       (sd_ack_i[x68k_timing_pkg::HDD_SLOT]),
		.active_o      (hdd_active_o)
	);

endmodule

`default_nettype wire

// File: hw/x68k_host_pkg.sv
/*
 Host controller word layouts.
 Bit positions in the 64-bit status word and the types for the
 joysticks and the per-drive masks.
*/
`default_nettype none

package x68k_host_pkg;

	localparam int STATUS_W = 64;

	typedef logic [STATUS_W-1:0] status_word_t;

	// Status word bit positions
	localparam int ST_RESET = 0;
	localparam int ST_VID_HZ = 3;
	localparam int ST_TURBO = 4;
	localparam int ST_NMI = 7;
	localparam int ST_POWER = 8;
	localparam int ST_FDSYNC_LO = 9;
	localparam int ST_EJECT_LO = 11;
	localparam int ST_SRAM_LD = 13;
	localparam int ST_SRAM_ST = 14;

	// Host pad: directions in 3:0, fire in 5:4, diagonal aliases in 7:6
	typedef logic [15:0] host_joy_t;
	// Core pad, active low
	typedef logic [5:0] core_joy_t;

	typedef logic [x68k_timing_pkg::NUM_DRIVES-1:0] drive_mask_t;
	typedef logic [x68k_timing_pkg::NUM_FDD-1:0] fdd_mask_t;

endpackage

`default_nettype wire

// File: hw/x68k_timing_pkg.sv
/*
 Timing constants for the X68000 glue logic.
 Holds the drive counts, the clock enable divider ratios and the
 default hold lengths that the top level passes to its blocks.
*/
`default_nettype none

package x68k_timing_pkg;

	// Image slots: two floppies, the hard disk, then SRAM
	localparam int NUM_DRIVES = 4;
	localparam int NUM_FDD = 2;
	localparam int HDD_SLOT = 2;

	// Enable periods in clk_sys cycles
	localparam int SYS_CE_DIV = 4;
	localparam int SND_DIV_FAST = 5;
	localparam int SND_DIV_SLOW = 10;
	localparam int OPM_DIV_A = 10;
	localparam int OPM_DIV_B = 20;

	// Hold lengths for a 40 MHz system clock
	// Mount eject phase, roughly 0.4 s
	localparam int DEF_MOUNT_EJECT_LEN = 16711680;
	localparam int DEF_MOUNT_PRESENT_LEN = 65535;
	localparam int DEF_EJECT_LEN = 65535;
	localparam int DEF_HDD_RESET_LEN = 65535;
	// Disk light stays on about 0.1 s after the last access
	localparam int DEF_LED_HOLD_LEN = 4500000;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the glue testbench with Verilator and run it.
# Exit status is zero only when the pass line is printed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_glue_top \
	-f sources.f \
	-o sim_tb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

output="$(./obj_dir/sim_tb 2>&1)"
run_status=$?
echo "$output"

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
	exit 0
else
	exit 1
fi

// File: sources.f
hw/x68k_timing_pkg.sv
hw/x68k_host_pkg.sv
hw/host_status_regs.sv
hw/clock_enable_gen.sv
hw/media_reset_seq.sv
hw/loader_bridge.sv
hw/activity_led.sv
hw/x68k_glue_top.sv
testbench/tb_glue_top.sv

// File: testbench/tb_glue_top.sv
/*
 Testbench for the X68000 glue top level.
 Drives host status, pads, mounts, downloads and acknowledges, and
 checks the core-side outputs with assertions. Stops on the first error.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_glue_top;

	localparam int CLK_PERIOD = 40;
	localparam int TEST_CYCLES = 900;
	localparam int MOUNT_EJECT = 20;
	localparam int MOUNT_PRESENT = 15;
	localparam int BTN_EJECT = 12;
	localparam int HDD_RESET = 25;
	localparam int LED_HOLD = 30;

	logic clk_sys;
	logic reset_delayed;
	logic [63:0] status_i;
	logic [15:0] joy0_i;
	logic [15:0] joy1_i;
	logic [1:0] buttons_i;
	logic [3:0] img_mounted_i;
	logic [3:0] sd_ack_i;
	logic ioctl_download_i;
	logic ioctl_wr_i;
	logic [19:0] ioctl_addr_i;
	logic [7:0] ioctl_dout_i;
	logic snd_clockmode_i;
	logic ldr_ack_i;
	wire sys_ce_o, mpu_cep_o, mpu_cen_o, snd_ce_o;
	wire [1:0] opm_ce_o;
	wire core_rst_n_o;
	wire [1:0] fdd_eject_o, fdd_mounted_o, fdsync_o, psw_n_o;
	wire hdd_mounted_o, sram_mounted_o, vid_hz_o, sram_ld_o, sram_st_o;
	wire [5:0] core_joy_a_o, core_joy_b_o;
	wire [19:0] ldr_addr_o;
	wire [7:0] ldr_wdat_o;
	wire ldr_wr_o, ldr_aen_o, ldr_done_o, download_led_o;
	wire fdd_active_o, hdd_active_o;

	// Checker state kept by the testbench
	logic checks_on;
	int cpu_check;
	int snd_check;
	logic init_fell;
	logic boot_started;
	int btn_cycles;
	int fail_count;
	logic [19:0] exp_addr;
	logic [7:0] exp_data;
	logic [15:0] joy0_q, joy1_q;
	logic [63:0] status_q;
	logic [19:0] sys_h, cep_h, cen_h, snd_h, opm0_h, opm1_h;
	logic [2:0] wr_h, ack_h, dl_h, lwr_h, done_h;

	x68k_glue_top #(
		.MOUNT_EJECT_LEN   (MOUNT_EJECT),
		.MOUNT_PRESENT_LEN (MOUNT_PRESENT),
		.EJECT_LEN         (BTN_EJECT),
		.HDD_RESET_LEN     (HDD_RESET),
		.LED_HOLD_LEN      (LED_HOLD)
	) u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	task automatic stop_run();
		fail_count++;
		$display("RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_value(input string name, input longint exp, input longint act);
		$display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		stop_run();
	endtask

	// Exactly one pulse in every window of p samples, repeating at p
	function automatic bit spaced(input logic [19:0] h, input logic cur, input int p);
		int ones;
		ones = cur ? 1 : 0;
		for (int i = 0; i < p - 1; i++)
			ones += h[i] ? 1 : 0;
		return (cur == h[p-1]) && (ones == 1);
	endfunction

	// Core pad: fire 2, fire 1, up, down, left, right with aliases, active low
	function automatic logic [5:0] joy_expect(input logic [15:0] j);
		logic [5:0] w;
		w[5] = j[5];
		w[4] = j[4];
		w[3] = j[0] | j[6];
		w[2] = j[1] | j[6];
		w[1] = j[2] | j[7];
		w[0] = j[3] | j[7];
		return ~w;
	endfunction

	function automatic logic sig_level(input int which);
		case (which)
			0: return fdd_eject_o[0];
			1: return fdd_mounted_o[0];
			2: return fdd_eject_o[1];
			3: return hdd_mounted_o;
			4: return core_rst_n_o;
			5: return !core_rst_n_o;
			6: return fdd_active_o;
			7: return hdd_active_o;
			default: return sram_mounted_o;
		endcase
	endfunction

	task automatic wait_level(input int which, input int limit, input string name);
		int waited;
		waited = 0;
		while (!sig_level(which)) begin
			if (waited >= limit) begin
				$display("Timeout: %s never went high", name);
				stop_run();
			end
			@(posedge clk_sys);
			waited++;
		end
	endtask

	task automatic measure_run(input int which, input int exp, input string name);
		int cnt;
		wait_level(which, 10, name);
		cnt = 0;
		while (sig_level(which) && cnt <= exp + 10) begin
			cnt++;
			@(posedge clk_sys);
		end
		assert (cnt >= exp - 2 && cnt <= exp + 2)
		else report_value({name, " high cycles"}, exp, cnt);
	endtask

	task automatic loader_write(input logic [19:0] addr, input logic [7:0] data);
		int delay;
		ioctl_wr_i <= 1'b1;
		ioctl_addr_i <= addr;
		ioctl_dout_i <= data;
		exp_addr <= addr;
		exp_data <= data;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		delay = $urandom_range(6, 1);
		repeat (delay) @(posedge clk_sys);
		ldr_ack_i <= 1'b1;
		@(posedge clk_sys);
		ldr_ack_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sample history

	always @(posedge clk_sys) begin
		sys_h <= {sys_h[18:0], sys_ce_o};
		cep_h <= {cep_h[18:0], mpu_cep_o};
		cen_h <= {cen_h[18:0], mpu_cen_o};
		snd_h <= {snd_h[18:0], snd_ce_o};
		opm0_h <= {opm0_h[18:0], opm_ce_o[0]};
		opm1_h <= {opm1_h[18:0], opm_ce_o[1]};
		wr_h <= {wr_h[1:0], ioctl_wr_i};
		ack_h <= {ack_h[1:0], ldr_ack_i};
		dl_h <= {dl_h[1:0], ioctl_download_i};
		lwr_h <= {lwr_h[1:0], ldr_wr_o};
		done_h <= {done_h[1:0], ldr_done_o};
		joy0_q <= joy0_i;
		joy1_q <= joy1_i;
		status_q <= status_i;
		btn_cycles <= buttons_i[1] ? btn_cycles + 1 : 0;
	end

	//////////////////////////////////////////////////////////////////////
	// Assertions

	assert property (@(posedge clk_sys) disable iff (!checks_on) spaced(sys_h, sys_ce_o, 4))
	else report_value("sys_ce_o", $sampled(sys_h[3]), $sampled(sys_ce_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on) !(mpu_cep_o && mpu_cen_o))
	else report_value("mpu_cen_o", 0, $sampled(mpu_cen_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		cpu_check == 1 |-> spaced(cep_h, mpu_cep_o, 4))
	else report_value("mpu_cep_o", $sampled(cep_h[3]), $sampled(mpu_cep_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		cpu_check == 1 |-> spaced(cen_h, mpu_cen_o, 4))
	else report_value("mpu_cen_o", $sampled(cen_h[3]), $sampled(mpu_cen_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		cpu_check == 2 |-> mpu_cep_o != cep_h[0] && mpu_cep_o != mpu_cen_o)
	else report_value("mpu_cep_o", $sampled(!cep_h[0]), $sampled(mpu_cep_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		snd_check != 0 |-> spaced(snd_h, snd_ce_o, snd_check == 1 ? 5 : 10))
	else report_value("snd_ce_o", $sampled(snd_check == 1 ? snd_h[4] : snd_h[9]),
		$sampled(snd_ce_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		spaced(opm0_h, opm_ce_o[0], 10) && spaced(opm1_h, opm_ce_o[1], 20))
	else report_value("opm_ce_o", {$sampled(opm1_h[19]), $sampled(opm0_h[9])}, $sampled(opm_ce_o));

	// Loader handshake
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		wr_h[0] |-> ldr_wr_o)
	else report_value("ldr_wr_o", 1, $sampled(ldr_wr_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		wr_h[0] |-> ldr_addr_o == exp_addr)
	else report_value("ldr_addr_o", $sampled(exp_addr), $sampled(ldr_addr_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		wr_h[0] |-> ldr_wdat_o == exp_data)
	else report_value("ldr_wdat_o", $sampled(exp_data), $sampled(ldr_wdat_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		lwr_h[0] && !wr_h[0] && !(ack_h[0] && !ack_h[1]) |-> ldr_wr_o)
	else report_value("ldr_wr_o", 1, $sampled(ldr_wr_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		!wr_h[0] && ack_h[0] && !ack_h[1] |-> !ldr_wr_o)
	else report_value("ldr_wr_o", 0, $sampled(ldr_wr_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		ldr_done_o == (done_h[0] || (dl_h[1] && !dl_h[0])))
	else report_value("ldr_done_o", $sampled(done_h[0] || (dl_h[1] && !dl_h[0])),
		$sampled(ldr_done_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		ldr_aen_o == (dl_h[0] && !done_h[0]))
	else report_value("ldr_aen_o", $sampled(dl_h[0] && !done_h[0]), $sampled(ldr_aen_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		download_led_o == !dl_h[0])
	else report_value("download_led_o", $sampled(!dl_h[0]), $sampled(download_led_o));

	// Core reset, media and pads
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		!(init_fell && boot_started) || btn_cycles >= 3 |-> !core_rst_n_o)
	else report_value("core_rst_n_o", 0, $sampled(core_rst_n_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		(fdd_eject_o & fdd_mounted_o) == 2'b00)
	else report_value("fdd_mounted_o", 0, $sampled(fdd_mounted_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		core_joy_a_o == joy_expect(joy0_q))
	else report_value("core_joy_a_o", joy_expect($sampled(joy0_q)), $sampled(core_joy_a_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		core_joy_b_o == joy_expect(joy1_q))
	else report_value("core_joy_b_o", joy_expect($sampled(joy1_q)), $sampled(core_joy_b_o));

	// Decoded status fields
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		vid_hz_o == !status_q[x68k_host_pkg::ST_VID_HZ])
	else report_value("vid_hz_o", $sampled(!status_q[x68k_host_pkg::ST_VID_HZ]),
		$sampled(vid_hz_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		psw_n_o[1] == !status_q[x68k_host_pkg::ST_NMI] &&
		psw_n_o[0] == !status_q[x68k_host_pkg::ST_POWER])
	else report_value("psw_n_o", $sampled({!status_q[x68k_host_pkg::ST_NMI],
		!status_q[x68k_host_pkg::ST_POWER]}), $sampled(psw_n_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		fdsync_o == status_q[x68k_host_pkg::ST_FDSYNC_LO +: 2])
	else report_value("fdsync_o", $sampled(status_q[x68k_host_pkg::ST_FDSYNC_LO +: 2]),
		$sampled(fdsync_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		sram_ld_o == status_q[x68k_host_pkg::ST_SRAM_LD])
	else report_value("sram_ld_o", $sampled(status_q[x68k_host_pkg::ST_SRAM_LD]),
		$sampled(sram_ld_o));
	assert property (@(posedge clk_sys) disable iff (!checks_on)
		sram_st_o == status_q[x68k_host_pkg::ST_SRAM_ST])
	else report_value("sram_st_o", $sampled(status_q[x68k_host_pkg::ST_SRAM_ST]),
		$sampled(sram_st_o));

	// Watchdog sized from the test length
	initial begin
		#((TEST_CYCLES + 400) * CLK_PERIOD);
		$display("Timeout: the run did not finish in the expected time");
		stop_run();
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		void'($urandom(57730));
		fail_count = 0;
		checks_on = 1'b0;
		cpu_check = 0;
		snd_check = 0;
		init_fell = 1'b0;
		boot_started = 1'b0;
		btn_cycles = 0;
		exp_addr = '0;
		exp_data = '0;
		reset_delayed = 1'b1;
		status_i = 64'h1;
		joy0_i = '0;
		joy1_i = '0;
		buttons_i = '0;
		img_mounted_i = '0;
		sd_ack_i = '0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_dout_i = '0;
		snd_clockmode_i = 1'b0;
		ldr_ack_i = 1'b0;
		repeat (4) @(posedge clk_sys);
		reset_delayed <= 1'b0;
		repeat (24) @(posedge clk_sys);
		checks_on <= 1'b1;
		cpu_check <= 1;
		snd_check <= 1;
		repeat (40) @(posedge clk_sys);

		// Turbo and sound mode switches
		status_i[x68k_host_pkg::ST_TURBO] <= 1'b1;
		cpu_check <= 0;
		repeat (8) @(posedge clk_sys);
		cpu_check <= 2;
		repeat (30) @(posedge clk_sys);
		snd_clockmode_i <= 1'b1;
		snd_check <= 0;
		repeat (22) @(posedge clk_sys);
		snd_check <= 2;
		repeat (40) @(posedge clk_sys);

		// Release host reset, then start the download
		status_i[x68k_host_pkg::ST_RESET] <= 1'b0;
		init_fell <= 1'b1;
		repeat (6) @(posedge clk_sys);
		ioctl_download_i <= 1'b1;
		boot_started <= 1'b1;
		@(posedge clk_sys);
		wait_level(4, 10, "core_rst_n_o");
		for (int i = 0; i < 6; i++)
			loader_write(20'($urandom), 8'($urandom));
		ioctl_download_i <= 1'b0;
		repeat (6) @(posedge clk_sys);

		buttons_i <= 2'b10;
		repeat (8) @(posedge clk_sys);
		buttons_i <= 2'b00;
		wait_level(4, 10, "core_rst_n_o");

		// Mount both floppies, eject drive 1 while it shows present
		img_mounted_i <= 4'b0011;
		@(posedge clk_sys);
		img_mounted_i <= 4'b0000;
		measure_run(0, MOUNT_EJECT, "fdd_eject_o[0]");
		fork
			measure_run(1, MOUNT_PRESENT, "fdd_mounted_o[0]");
			begin
				status_i[x68k_host_pkg::ST_EJECT_LO + 1] <= 1'b1;
				@(posedge clk_sys);
				status_i[x68k_host_pkg::ST_EJECT_LO + 1] <= 1'b0;
				measure_run(2, BTN_EJECT, "fdd_eject_o[1]");
			end
		join

		img_mounted_i <= 4'b0100;
		@(posedge clk_sys);
		img_mounted_i <= 4'b0000;
		fork
			measure_run(3, MOUNT_EJECT + MOUNT_PRESENT, "hdd_mounted_o");
			measure_run(5, HDD_RESET, "core_rst_n_o low");
		join
		wait_level(4, 10, "core_rst_n_o");

		img_mounted_i <= 4'b1000;
		@(posedge clk_sys);
		img_mounted_i <= 4'b0000;
		measure_run(8, MOUNT_EJECT + MOUNT_PRESENT, "sram_mounted_o");

		// Activity lights, pads and status fields
		sd_ack_i <= 4'b0010;
		@(posedge clk_sys);
		sd_ack_i <= 4'b0000;
		measure_run(6, LED_HOLD, "fdd_active_o");
		sd_ack_i <= 4'b0100;
		@(posedge clk_sys);
		sd_ack_i <= 4'b0000;
		measure_run(7, LED_HOLD, "hdd_active_o");
		for (int i = 0; i < 8; i++) begin
			joy0_i <= 16'($urandom);
			joy1_i <= 16'($urandom);
			status_i[x68k_host_pkg::ST_VID_HZ] <= 1'($urandom);
			status_i[x68k_host_pkg::ST_NMI] <= 1'($urandom);
			status_i[x68k_host_pkg::ST_POWER] <= 1'($urandom);
			status_i[x68k_host_pkg::ST_FDSYNC_LO +: 2] <= 2'($urandom);
			status_i[x68k_host_pkg::ST_SRAM_LD] <= 1'($urandom);
			status_i[x68k_host_pkg::ST_SRAM_ST] <= 1'($urandom);
			repeat (4) @(posedge clk_sys);
		end

		if (fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

`default_nettype wire
